//--- rtl/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  localparam int XLEN        = 32;
  localparam int ROB_TAG_W   = 5;  // 32 tags in flight at most
  localparam int RS_DEPTH    = 4;
  localparam int RS_IDX_W    = $clog2(RS_DEPTH);
  localparam int MUL_LATENCY = 3;  // dispatch edge to result valid, must be 2 or more

  // multiplier countdown, loaded on capture and fires at zero
  localparam int MUL_CNT_W = (MUL_LATENCY > 2) ? $clog2(MUL_LATENCY) : 1;
  localparam logic [MUL_CNT_W-1:0] MUL_CNT_INIT = MUL_CNT_W'(MUL_LATENCY - 2);

  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_MUL = 1'b1
  } unit_e;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9
  } alu_func_e;

  // one operand word, either a value or the tag of its pending producer
  typedef union packed {
    logic [XLEN-1:0] value;
    struct packed {
      logic [XLEN-ROB_TAG_W-1:0] pad;
      logic [ROB_TAG_W-1:0]      tag;
    } pend;
  } operand_payload_u;

  typedef struct packed {
    logic             ready;  // selects the union view
    operand_payload_u payload;
  } operand_t;

  typedef struct packed {
    logic                 valid;
    unit_e                unit;
    alu_func_e            func;
    logic [ROB_TAG_W-1:0] tag;
    operand_t             src_a;
    operand_t             src_b;
  } issue_t;

  typedef struct packed {
    logic                 valid;
    alu_func_e            func;
    logic [ROB_TAG_W-1:0] tag;
    logic [XLEN-1:0]      a;
    logic [XLEN-1:0]      b;
  } fu_req_t;

  typedef struct packed {
    logic                 valid;
    logic [ROB_TAG_W-1:0] tag;
    logic [XLEN-1:0]      value;
  } fu_result_t;

  typedef struct packed {
    logic                 valid;
    logic [ROB_TAG_W-1:0] tag;
    logic [XLEN-1:0]      value;
  } cdb_t;

endpackage

`default_nettype wire

//--- rtl/issue_router.sv
`default_nettype none

module issue_router (
  input  wire ooo_pkg::issue_t i_issue,
  input  wire                  i_alu_free,
  input  wire                  i_mul_free,
  output logic                 o_alu_accept,
  output logic                 o_mul_accept,
  output logic                 o_issue_ready
);

  logic to_alu;

  assign to_alu = (i_issue.unit == ooo_pkg::UNIT_ALU);

  // ready only looks at the station the op is steered to
  assign o_issue_ready = to_alu ? i_alu_free : i_mul_free;

  always_comb begin
    o_alu_accept = i_issue.valid && to_alu && i_alu_free;
    o_mul_accept = i_issue.valid && !to_alu && i_mul_free;
  end

endmodule

`default_nettype wire

//--- rtl/reservation_station.sv
`default_nettype none

module reservation_station (
  input  wire                  clk_100mhz,
  input  wire                  sys_rst,
  input  wire                  i_flush,
  input  wire                  i_accept,
  input  wire ooo_pkg::issue_t i_issue,
  input  wire ooo_pkg::cdb_t   i_cdb,
  input  wire                  i_unit_busy,
  output logic                 o_free,
  output ooo_pkg::fu_req_t     o_req
);

  ooo_pkg::issue_t ent [ooo_pkg::RS_DEPTH];
  ooo_pkg::issue_t wr_ent;

  logic [ooo_pkg::RS_DEPTH-1:0] free_vec;
  logic [ooo_pkg::RS_DEPTH-1:0] rdy_vec;
  logic [ooo_pkg::RS_IDX_W-1:0] wr_idx;
  logic [ooo_pkg::RS_IDX_W-1:0] disp_idx;
  logic                         dispatch;

  // grab the broadcast value if this operand waits on its tag
  function automatic ooo_pkg::operand_t snoop(input ooo_pkg::operand_t op,
                                              input ooo_pkg::cdb_t cdb);
    ooo_pkg::operand_t res;
    res = op;
    if (!op.ready && cdb.valid && (cdb.tag == op.payload.pend.tag)) begin
      res.ready         = 1'b1;
      res.payload.value = cdb.value;
    end
    return res;
  endfunction

  always_comb begin
    for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
      free_vec[i] = !ent[i].valid;
      rdy_vec[i]  = ent[i].valid && ent[i].src_a.ready && ent[i].src_b.ready;
    end
  end

  // walk down so the lowest index wins
  always_comb begin
    wr_idx   = '0;
    disp_idx = '0;
    for (int i = ooo_pkg::RS_DEPTH - 1; i >= 0; i--) begin
      if (free_vec[i]) wr_idx = i[ooo_pkg::RS_IDX_W-1:0];
      if (rdy_vec[i]) disp_idx = i[ooo_pkg::RS_IDX_W-1:0];
    end
  end

  assign o_free   = |free_vec;
  assign dispatch = (|rdy_vec) && !i_unit_busy;

  // incoming op, with a same-cycle bus capture folded in
  always_comb begin
    wr_ent       = i_issue;
    wr_ent.valid = 1'b1;
    wr_ent.src_a = snoop(i_issue.src_a, i_cdb);
    wr_ent.src_b = snoop(i_issue.src_b, i_cdb);
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst || i_flush) begin
      for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
        ent[i].valid <= 1'b0;
      end
      o_req.valid <= 1'b0;
    end else begin
      for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
        if (i_accept && (wr_idx == i[ooo_pkg::RS_IDX_W-1:0])) begin
          ent[i] <= wr_ent;
        end else if (dispatch && (disp_idx == i[ooo_pkg::RS_IDX_W-1:0])) begin
          ent[i].valid <= 1'b0;  // frees on the dispatch edge
        end else begin
          ent[i].src_a <= snoop(ent[i].src_a, i_cdb);
          ent[i].src_b <= snoop(ent[i].src_b, i_cdb);
        end
      end

      o_req.valid <= dispatch;  // one-cycle pulse
      if (dispatch) begin
        o_req.func <= ent[disp_idx].func;
        o_req.tag  <= ent[disp_idx].tag;
        o_req.a    <= ent[disp_idx].src_a.payload.value;
        o_req.b    <= ent[disp_idx].src_b.payload.value;
      end
    end
  end

  // issue side must respect o_free through the router
  a_accept_needs_room: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_accept |-> o_free)
    else $error("accept into a full station");

endmodule

`default_nettype wire

//--- rtl/int_alu.sv
`default_nettype none

module int_alu (
  input  wire                   clk_100mhz,
  input  wire                   sys_rst,
  input  wire                   i_flush,
  input  wire ooo_pkg::fu_req_t i_req,
  input  wire                   i_grant,
  output logic                  o_busy,
  output ooo_pkg::fu_result_t   o_result
);

  logic [ooo_pkg::XLEN-1:0] alu_out;
  logic [4:0]               shamt;
  logic                     held;

  assign shamt  = i_req.b[4:0];
  assign held   = o_result.valid && !i_grant;  // a granted result is gone next edge
  assign o_busy = i_req.valid || held;

  always_comb begin
    alu_out = '0;
    case (i_req.func)
      ooo_pkg::ADD:  alu_out = i_req.a + i_req.b;
      ooo_pkg::SUB:  alu_out = i_req.a - i_req.b;
      ooo_pkg::AND:  alu_out = i_req.a & i_req.b;
      ooo_pkg::OR:   alu_out = i_req.a | i_req.b;
      ooo_pkg::XOR:  alu_out = i_req.a ^ i_req.b;
      ooo_pkg::SLL:  alu_out = i_req.a << shamt;
      ooo_pkg::SRL:  alu_out = i_req.a >> shamt;
      ooo_pkg::SRA:  alu_out = $signed(i_req.a) >>> shamt;
      ooo_pkg::SLT:  alu_out[0] = $signed(i_req.a) < $signed(i_req.b);
      ooo_pkg::SLTU: alu_out[0] = i_req.a < i_req.b;
      default:       alu_out = '0;
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst || i_flush) begin
      o_result.valid <= 1'b0;
    end else if (i_req.valid) begin
      o_result.valid <= 1'b1;
      o_result.tag   <= i_req.tag;
      o_result.value <= alu_out;
    end else if (i_grant) begin
      o_result.valid <= 1'b0;
    end
  end

  // station must wait until the arbiter has taken the last result
  a_no_req_when_held: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_req.valid |-> !held)
    else $error("alu request while a result is held");

endmodule

`default_nettype wire

//--- rtl/multiplier.sv
`default_nettype none

module multiplier (
  input  wire                   clk_100mhz,
  input  wire                   sys_rst,
  input  wire                   i_flush,
  input  wire ooo_pkg::fu_req_t i_req,
  input  wire                   i_grant,
  output logic                  o_busy,
  output ooo_pkg::fu_result_t   o_result
);

  logic                          running;
  logic [ooo_pkg::MUL_CNT_W-1:0] cnt;
  logic [ooo_pkg::XLEN-1:0]      a_q;
  logic [ooo_pkg::XLEN-1:0]      b_q;
  logic                          held;

  assign held   = running || (o_result.valid && !i_grant);
  assign o_busy = i_req.valid || held;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst || i_flush) begin
      running        <= 1'b0;
      o_result.valid <= 1'b0;
    end else if (i_req.valid) begin
      running      <= 1'b1;
      cnt          <= ooo_pkg::MUL_CNT_INIT;
      a_q          <= i_req.a;
      b_q          <= i_req.b;
      o_result.tag <= i_req.tag;  // func is ignored here
    end else if (running) begin
      if (cnt == '0) begin
        running        <= 1'b0;
        o_result.valid <= 1'b1;
        o_result.value <= a_q * b_q;  // low XLEN bits of the product
      end else begin
        cnt <= cnt - 1'b1;
      end
    end else if (i_grant) begin
      o_result.valid <= 1'b0;
    end
  end

  // one multiply in flight, from dispatch through grant
  a_no_req_when_held: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_req.valid |-> !held)
    else $error("mul request while busy");

endmodule

`default_nettype wire

//--- rtl/cdb_arbiter.sv
`default_nettype none

module cdb_arbiter (
  input  wire                      clk_100mhz,
  input  wire                      sys_rst,
  input  wire                      i_flush,
  input  wire ooo_pkg::fu_result_t i_alu_result,
  input  wire ooo_pkg::fu_result_t i_mul_result,
  output logic                     o_alu_grant,
  output logic                     o_mul_grant,
  output ooo_pkg::cdb_t            o_cdb
);

  logic alu_pending;
  logic mul_pending;

  // a result under grant is still valid this cycle but already on the bus
  assign alu_pending = i_alu_result.valid && !o_alu_grant;
  assign mul_pending = i_mul_result.valid && !o_mul_grant;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst || i_flush) begin
      o_cdb.valid <= 1'b0;
      o_alu_grant <= 1'b0;
      o_mul_grant <= 1'b0;
    end else begin
      o_cdb.valid <= alu_pending || mul_pending;
      o_alu_grant <= alu_pending;                 // alu always wins
      o_mul_grant <= mul_pending && !alu_pending;
      if (alu_pending) begin
        o_cdb.tag   <= i_alu_result.tag;
        o_cdb.value <= i_alu_result.value;
      end else begin
        o_cdb.tag   <= i_mul_result.tag;
        o_cdb.value <= i_mul_result.value;
      end
    end
  end

  // a granted unit drops its result on the next edge
  a_alu_release: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_alu_grant |=> !i_alu_result.valid)
    else $error("alu result still valid after its grant");

  a_mul_release: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_mul_grant |=> !i_mul_result.valid)
    else $error("mul result still valid after its grant");

endmodule

`default_nettype wire

//--- rtl/ooo_core_top.sv
`default_nettype none

module ooo_core_top (
  input  wire                  clk_100mhz,
  input  wire                  sys_rst,
  input  wire                  i_flush,
  input  wire ooo_pkg::issue_t i_issue,
  output logic                 o_issue_ready,
  output ooo_pkg::cdb_t        o_cdb
);

  logic                alu_accept, mul_accept;
  logic                alu_free, mul_free;
  logic                alu_busy, mul_busy;
  logic                alu_grant, mul_grant;
  ooo_pkg::fu_req_t    alu_req, mul_req;
  ooo_pkg::fu_result_t alu_result, mul_result;

  issue_router router (
    .i_issue       (i_issue),
    .i_alu_free    (alu_free),
    .i_mul_free    (mul_free),
    .o_alu_accept  (alu_accept),
    .o_mul_accept  (mul_accept),
    .o_issue_ready (o_issue_ready)
  );

  reservation_station rs_alu (
    .clk_100mhz  (clk_100mhz),
    .sys_rst     (sys_rst),
    .i_flush     (i_flush),
    .i_accept    (alu_accept),
    .i_issue     (i_issue),
    .i_cdb       (o_cdb),
    .i_unit_busy (alu_busy),
    .o_free      (alu_free),
    .o_req       (alu_req)
  );

  reservation_station rs_mul (
    .clk_100mhz  (clk_100mhz),
    .sys_rst     (sys_rst),
    .i_flush     (i_flush),
    .i_accept    (mul_accept),
    .i_issue     (i_issue),
    .i_cdb       (o_cdb),
    .i_unit_busy (mul_busy),
    .o_free      (mul_free),
    .o_req       (mul_req)
  );

  int_alu alu (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .i_flush    (i_flush),
    .i_req      (alu_req),
    .i_grant    (alu_grant),
    .o_busy     (alu_busy),
    .o_result   (alu_result)
  );

  multiplier mul (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .i_flush    (i_flush),
    .i_req      (mul_req),
    .i_grant    (mul_grant),
    .o_busy     (mul_busy),
    .o_result   (mul_result)
  );

  cdb_arbiter arbiter (
    .clk_100mhz   (clk_100mhz),
    .sys_rst      (sys_rst),
    .i_flush      (i_flush),
    .i_alu_result (alu_result),
    .i_mul_result (mul_result),
    .o_alu_grant  (alu_grant),
    .o_mul_grant  (mul_grant),
    .o_cdb        (o_cdb)
  );

endmodule

`default_nettype wire

//--- dv/ooo_core_tb.sv
`default_nettype none

module ooo_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // the six tests run in about two hundred cycles
  localparam int MAX_CYCLES = 2000;
  localparam int NTAGS      = 1 << ooo_pkg::ROB_TAG_W;

  logic            clk_100mhz = 1'b0;
  logic            sys_rst;
  logic            i_flush;
  ooo_pkg::issue_t i_issue;
  logic            o_issue_ready;
  ooo_pkg::cdb_t   o_cdb;

  int          cycle       = 0;
  int          errors      = 0;
  int          bcast_total = 0;
  logic [31:0] lfsr        = 32'h72f4c936;

  // scoreboard with one slot per rob tag
  logic        exp_valid    [NTAGS];
  logic [31:0] exp_value    [NTAGS];
  int          seen_count   [NTAGS];
  int          seen_cycle   [NTAGS];
  int          accept_cycle [NTAGS];

  ooo_core_top dut (
    .clk_100mhz    (clk_100mhz),
    .sys_rst       (sys_rst),
    .i_flush       (i_flush),
    .i_issue       (i_issue),
    .o_issue_ready (o_issue_ready),
    .o_cdb         (o_cdb)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  always @(posedge clk_100mhz) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("run stopped at the cycle limit of %0d", MAX_CYCLES);
      $display("%0d broadcasts seen, %0d errors", bcast_total, errors + 1);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // bus monitor samples mid-cycle where o_cdb is stable
  always @(negedge clk_100mhz) begin
    logic [ooo_pkg::ROB_TAG_W-1:0] t;
    t = o_cdb.tag;
    if (!sys_rst && o_cdb.valid) begin
      if (!exp_valid[t]) begin
        $display("%0t: tag %0d was broadcast but no test expects it", $time, t);
        errors++;
      end else if (seen_count[t] != 0) begin
        $display("%0t: tag %0d was broadcast more than once", $time, t);
        errors++;
      end else if (o_cdb.value != exp_value[t]) begin
        $display("Mismatch at %0t: o_cdb.value for tag %0d expected %h got %h",
                 $time, t, exp_value[t], o_cdb.value);
        errors++;
      end
      seen_count[t]++;
      seen_cycle[t] = cycle;
      bcast_total++;
    end
  end

  // taps for x^32 + x^22 + x^2 + x + 1 with one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] model_alu(input ooo_pkg::alu_func_e f,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] fill;
    sh   = b[4:0];
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;  // sign bits shifted in
    case (f)
      ooo_pkg::ADD:  return a + b;
      ooo_pkg::SUB:  return a + ~b + 32'd1;
      ooo_pkg::AND:  return a & b;
      ooo_pkg::OR:   return a | b;
      ooo_pkg::XOR:  return a ^ b;
      ooo_pkg::SLL:  return a << sh;
      ooo_pkg::SRL:  return a >> sh;
      ooo_pkg::SRA:  return (a >> sh) | fill;
      ooo_pkg::SLT:  return (a[31] != b[31]) ? {31'h0, a[31]} : {31'h0, a < b};
      ooo_pkg::SLTU: return {31'h0, a < b};
      default:       return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] model_mul(input logic [31:0] a, input logic [31:0] b);
    logic [63:0] p;
    p = {32'h0, a} * {32'h0, b};
    return p[31:0];  // low word only
  endfunction

  function automatic ooo_pkg::operand_t val_op(input logic [31:0] v);
    ooo_pkg::operand_t op;
    op.ready         = 1'b1;
    op.payload.value = v;
    return op;
  endfunction

  function automatic ooo_pkg::operand_t wait_op(input logic [ooo_pkg::ROB_TAG_W-1:0] t);
    ooo_pkg::operand_t op;
    op                  = '0;
    op.payload.pend.tag = t;
    return op;
  endfunction

  function automatic ooo_pkg::alu_func_e rand_func();
    return ooo_pkg::alu_func_e'(4'(take_bits(4) % 32'd10));
  endfunction

  task automatic clear_board();
    for (int t = 0; t < NTAGS; t++) begin
      exp_valid[t]  = 1'b0;
      exp_value[t]  = '0;
      seen_count[t] = 0;
      seen_cycle[t] = 0;
    end
  endtask

  task automatic expect_result(input int tag, input logic [31:0] value);
    exp_valid[tag] = 1'b1;
    exp_value[tag] = value;
  endtask

  // starts and ends on a falling edge
  task automatic issue_op(input ooo_pkg::unit_e unit, input ooo_pkg::alu_func_e func,
                          input int tag, input ooo_pkg::operand_t a,
                          input ooo_pkg::operand_t b);
    int waited;
    waited        = 0;
    i_issue.valid = 1'b1;
    i_issue.unit  = unit;
    i_issue.func  = func;
    i_issue.tag   = 5'(tag);
    i_issue.src_a = a;
    i_issue.src_b = b;
    #1;
    while (!o_issue_ready && waited < 50) begin
      @(negedge clk_100mhz);
      #1;
      waited++;
    end
    if (!o_issue_ready) begin
      $display("%0t: tag %0d was never accepted at issue", $time, tag);
      errors++;
    end else begin
      accept_cycle[tag] = cycle + 1;  // the coming edge takes it
      @(posedge clk_100mhz);
    end
    @(negedge clk_100mhz);
    i_issue.valid = 1'b0;
  endtask

  task automatic wait_results(input int target, input int budget);
    int spent;
    spent = 0;
    while (bcast_total < target && spent < budget) begin
      @(posedge clk_100mhz);
      spent++;
    end
    @(negedge clk_100mhz);
  endtask

  task automatic check_latency(input int tag, input int edges);
    if (seen_count[tag] != 0 && seen_cycle[tag] - accept_cycle[tag] != edges) begin
      $display("Mismatch at %0t: o_cdb latency for tag %0d expected %0d got %0d",
               $time, tag, edges, seen_cycle[tag] - accept_cycle[tag]);
      errors++;
    end
  endtask

  // reports missing tags and clears the board for the next test
  task automatic check_board();
    for (int t = 0; t < NTAGS; t++) begin
      if (exp_valid[t] && seen_count[t] == 0) begin
        $display("%0t: tag %0d was expected on the bus but never broadcast", $time, t);
        errors++;
      end
    end
    clear_board();
  endtask

  task automatic check_ready(input logic expected);
    if (o_issue_ready !== expected) begin
      $display("Mismatch at %0t: o_issue_ready expected %b got %b",
               $time, expected, o_issue_ready);
      errors++;
    end
  endtask

  task automatic alu_ops();
    logic [31:0] a;
    logic [31:0] b;
    int          start;
    start = bcast_total;
    for (int f = 0; f < 10; f++) begin
      a = take_bits(32);
      b = take_bits(32);
      expect_result(f, model_alu(ooo_pkg::alu_func_e'(4'(f)), a, b));
      issue_op(ooo_pkg::UNIT_ALU, ooo_pkg::alu_func_e'(4'(f)), f, val_op(a), val_op(b));
    end
    wait_results(start + 10, 200);
    check_board();
    a     = take_bits(32);
    b     = take_bits(32);
    start = bcast_total;
    expect_result(12, model_alu(ooo_pkg::ADD, a, b));
    issue_op(ooo_pkg::UNIT_ALU, ooo_pkg::ADD, 12, val_op(a), val_op(b));
    wait_results(start + 1, 20);
    check_latency(12, 3);
    check_board();
  endtask

  task automatic multiplies();
    logic [31:0] a;
    logic [31:0] b;
    int          start;
    start = bcast_total;
    for (int t = 0; t < 4; t++) begin
      a = take_bits(32);
      b = take_bits(32);
      expect_result(t, model_mul(a, b));
      issue_op(ooo_pkg::UNIT_MUL, ooo_pkg::ADD, t, val_op(a), val_op(b));
    end
    wait_results(start + 4, 100);
    check_board();
    a     = take_bits(32);
    b     = take_bits(32);
    start = bcast_total;
    expect_result(8, model_mul(a, b));
    issue_op(ooo_pkg::UNIT_MUL, ooo_pkg::ADD, 8, val_op(a), val_op(b));
    wait_results(start + 1, 20);
    check_latency(8, 2 + ooo_pkg::MUL_LATENCY);
    check_board();
  endtask

  task automatic bus_dependency();
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        c;
    ooo_pkg::alu_func_e f;
    int                 start;
    a     = take_bits(32);
    b     = take_bits(32);
    c     = take_bits(32);
    f     = rand_func();
    start = bcast_total;
    expect_result(1, model_mul(a, b));
    expect_result(2, model_alu(f, model_mul(a, b), c));
    issue_op(ooo_pkg::UNIT_MUL, ooo_pkg::ADD, 1, val_op(a), val_op(b));
    issue_op(ooo_pkg::UNIT_ALU, f, 2, wait_op(5'd1), val_op(c));  // src_a waits on tag 1
    wait_results(start + 2, 40);
    if (seen_count[1] != 0 && seen_count[2] != 0 && seen_cycle[2] <= seen_cycle[1]) begin
      $display("%0t: dependent tag 2 was broadcast before its producer", $time);
      errors++;
    end
    check_board();
  endtask

  task automatic contention();
    logic [31:0] a;
    logic [31:0] b;
    int          start;
    int          pairs;
    start = bcast_total;
    pairs = 0;
    for (int t = 0; t < 12; t++) begin
      a = take_bits(32);
      b = take_bits(32);
      if (t % 2 == 1) begin
        expect_result(t, model_mul(a, b));
        issue_op(ooo_pkg::UNIT_MUL, ooo_pkg::ADD, t, val_op(a), val_op(b));
      end else begin
        expect_result(t, model_alu(ooo_pkg::alu_func_e'(4'(t % 10)), a, b));
        issue_op(ooo_pkg::UNIT_ALU, ooo_pkg::alu_func_e'(4'(t % 10)), t,
                 val_op(a), val_op(b));
      end
    end
    wait_results(start + 12, 200);
    if (bcast_total - start != 12) begin
      $display("%0t: contention run saw %0d broadcasts instead of 12",
               $time, bcast_total - start);
      errors++;
    end
    // a multiply that loses to the alu takes the bus on the very next cycle
    for (int i = 0; i < 12; i += 2) begin
      for (int j = 1; j < 12; j += 2) begin
        if (seen_count[i] != 0 && seen_count[j] != 0 &&
            seen_cycle[j] == seen_cycle[i] + 1) begin
          pairs++;
        end
      end
    end
    if (pairs == 0) begin
      $display("%0t: no multiply result followed an alu result on the next bus cycle",
               $time);
      errors++;
    end
    check_board();
  endtask

  // fills the alu station with ops that wait on tag 31
  task automatic back_pressure();
    for (int t = 20; t < 20 + ooo_pkg::RS_DEPTH; t++) begin
      issue_op(ooo_pkg::UNIT_ALU, ooo_pkg::ADD, t, wait_op(5'd31), val_op(take_bits(32)));
    end
    i_issue.unit = ooo_pkg::UNIT_ALU;
    #1;
    check_ready(1'b0);
    i_issue.unit = ooo_pkg::UNIT_MUL;
    #1;
    check_ready(1'b1);
    repeat (10) @(negedge clk_100mhz);
  endtask

  task automatic flush_recovery();
    logic [31:0] a;
    logic [31:0] b;
    int          start;
    i_flush = 1'b1;
    @(negedge clk_100mhz);
    i_flush      = 1'b0;
    i_issue.unit = ooo_pkg::UNIT_ALU;
    #1;
    check_ready(1'b1);
    @(negedge clk_100mhz);
    a     = take_bits(32);
    b     = take_bits(32);
    start = bcast_total;
    expect_result(31, model_alu(ooo_pkg::ADD, a, b));
    issue_op(ooo_pkg::UNIT_ALU, ooo_pkg::ADD, 31, val_op(a), val_op(b));
    wait_results(start + 1, 20);
    check_latency(31, 3);
    repeat (10) @(negedge clk_100mhz);  // flushed waiters on tag 31 must stay silent
    check_board();
  endtask

  initial begin
    sys_rst = 1'b1;
    i_flush = 1'b0;
    i_issue = '0;
    clear_board();
    repeat (3) @(negedge clk_100mhz);
    sys_rst = 1'b0;
    #1;
    check_ready(1'b1);
    if (o_cdb.valid !== 1'b0) begin
      $display("Mismatch at %0t: o_cdb.valid expected 0 got %b", $time, o_cdb.valid);
      errors++;
    end
    @(negedge clk_100mhz);

    alu_ops();
    multiplies();
    bus_dependency();
    contention();
    back_pressure();
    flush_recovery();

    $display("%0d broadcasts seen, %0d errors", bcast_total, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ooo_core.f
rtl/ooo_pkg.sv
rtl/issue_router.sv
rtl/reservation_station.sv
rtl/int_alu.sv
rtl/multiplier.sv
rtl/cdb_arbiter.sv
rtl/ooo_core_top.sv
dv/ooo_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ooo_core_tb -f ooo_core.f -o sim_ooo_core

out="$(./obj_dir/sim_ooo_core)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
